// ==== src/fpr_cdb_pkg.sv ====
package fpr_cdb_pkg;

	////////////////////////////////////////////////////////////
	// unit ids carried by a bus slot reservation
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		unit_fdiv,
		unit_fsqrt,
		unit_fadd,
		unit_fmul,
		unit_itof,
		unit_lw,
		unit_fmov
	} fpr_unit_t;

	// one result word on the fp bus
	typedef logic [31:0] word_t;

	////////////////////////////////////////////////////////////
	// requester numbering
	////////////////////////////////////////////////////////////

	// width of the accepted vector
	localparam int n_req = 6;

	// bit positions in the accepted vector
	localparam int req_div  = 0;
	localparam int req_add  = 1;
	localparam int req_mul  = 2;
	localparam int req_itof = 3;
	localparam int req_lw   = 4;
	localparam int req_fmov = 5;

endpackage

// ==== src/fpr_cdb_grant.sv ====
`timescale 1ns/1ps

module fpr_cdb_grant #(
	parameter int DIV_SLOT  = 13,
	parameter int ADD_SLOT  = 5,
	parameter int MUL_SLOT  = 3,
	parameter int ITOF_SLOT = 2
) (
	input  logic [DIV_SLOT:0]                  occupied,
	input  logic                               div_valid,
	input  logic                               add_valid,
	input  logic                               mul_valid,
	input  logic                               itof_valid,
	input  logic                               lw_valid,
	input  logic                               fmov_valid,
	output logic                               add_ready,
	output logic                               mul_ready,
	output logic                               itof_ready,
	output logic                               lw_ready,
	output logic                               fmov_ready,
	output logic [fpr_cdb_pkg::n_req-1:0]      accepted
);

	////////////////////////////////////////////////////////////
	// per-unit ready
	////////////////////////////////////////////////////////////

	// slot s+1 shifts into s on this edge, so it must be free
	assign add_ready  = !occupied[ADD_SLOT+1];
	assign mul_ready  = !occupied[MUL_SLOT+1];
	assign itof_ready = !occupied[ITOF_SLOT+1];

	// load and move share slot 0, load wins
	assign lw_ready   = !occupied[1];
	assign fmov_ready = !occupied[1] && !lw_valid;

	////////////////////////////////////////////////////////////
	// accepted requests
	////////////////////////////////////////////////////////////

	// divide owns the top slot and never waits
	assign accepted[fpr_cdb_pkg::req_div]  = div_valid;
	assign accepted[fpr_cdb_pkg::req_add]  = add_valid  && add_ready;
	assign accepted[fpr_cdb_pkg::req_mul]  = mul_valid  && mul_ready;
	assign accepted[fpr_cdb_pkg::req_itof] = itof_valid && itof_ready;
	assign accepted[fpr_cdb_pkg::req_lw]   = lw_valid   && lw_ready;
	assign accepted[fpr_cdb_pkg::req_fmov] = fmov_valid && fmov_ready;

endmodule

// ==== src/fpr_cdb_slots.sv ====
`timescale 1ns/1ps

module fpr_cdb_slots #(
	parameter int TAG_W     = 5,
	parameter int DIV_SLOT  = 13,
	parameter int ADD_SLOT  = 5,
	parameter int MUL_SLOT  = 3,
	parameter int ITOF_SLOT = 2
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic [fpr_cdb_pkg::n_req-1:0]      accepted,
	input  logic                               div_is_sqrt,
	input  logic [TAG_W-1:0]                   div_tag,
	input  logic [TAG_W-1:0]                   add_tag,
	input  logic [TAG_W-1:0]                   mul_tag,
	input  logic [TAG_W-1:0]                   itof_tag,
	input  logic [TAG_W-1:0]                   lw_tag,
	input  logic [TAG_W-1:0]                   fmov_tag,
	output logic [DIV_SLOT:0]                  occupied,
	output logic                               head_valid,
	output logic [TAG_W-1:0]                   head_tag,
	output fpr_cdb_pkg::fpr_unit_t             head_unit
);

	// reservation entries, slot 0 is the next one on the bus
	logic [DIV_SLOT:0]          valid_q;
	logic [DIV_SLOT:0]          valid_d;
	logic [TAG_W-1:0]           tag_q  [DIV_SLOT:0];
	logic [TAG_W-1:0]           tag_d  [DIV_SLOT:0];
	fpr_cdb_pkg::fpr_unit_t     unit_q [DIV_SLOT:0];
	fpr_cdb_pkg::fpr_unit_t     unit_d [DIV_SLOT:0];

	////////////////////////////////////////////////////////////
	// shift down and merge new reservations
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < DIV_SLOT; i++) begin
			valid_d[i] = valid_q[i+1];
			tag_d[i]   = tag_q[i+1];
			unit_d[i]  = unit_q[i+1];
		end

		// top slot only ever takes a divide
		valid_d[DIV_SLOT] = accepted[fpr_cdb_pkg::req_div];
		tag_d[DIV_SLOT]   = div_tag;
		unit_d[DIV_SLOT]  = div_is_sqrt ? fpr_cdb_pkg::unit_fsqrt : fpr_cdb_pkg::unit_fdiv;

		// grant keeps these slots free of shifted entries
		if (accepted[fpr_cdb_pkg::req_add]) begin
			valid_d[ADD_SLOT] = 1'b1;
			tag_d[ADD_SLOT]   = add_tag;
			unit_d[ADD_SLOT]  = fpr_cdb_pkg::unit_fadd;
		end
		if (accepted[fpr_cdb_pkg::req_mul]) begin
			valid_d[MUL_SLOT] = 1'b1;
			tag_d[MUL_SLOT]   = mul_tag;
			unit_d[MUL_SLOT]  = fpr_cdb_pkg::unit_fmul;
		end
		if (accepted[fpr_cdb_pkg::req_itof]) begin
			valid_d[ITOF_SLOT] = 1'b1;
			tag_d[ITOF_SLOT]   = itof_tag;
			unit_d[ITOF_SLOT]  = fpr_cdb_pkg::unit_itof;
		end

		// slot 0, at most one of load or move
		if (accepted[fpr_cdb_pkg::req_lw]) begin
			valid_d[0] = 1'b1;
			tag_d[0]   = lw_tag;
			unit_d[0]  = fpr_cdb_pkg::unit_lw;
		end else if (accepted[fpr_cdb_pkg::req_fmov]) begin
			valid_d[0] = 1'b1;
			tag_d[0]   = fmov_tag;
			unit_d[0]  = fpr_cdb_pkg::unit_fmov;
		end
	end

	////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			valid_q <= valid_d;
		end
	end

	always_ff @(posedge clk) begin
		tag_q  <= tag_d;
		unit_q <= unit_d;
	end

	assign occupied   = valid_q;
	assign head_valid = valid_q[0];
	assign head_tag   = tag_q[0];
	assign head_unit  = unit_q[0];

endmodule

// ==== src/fpr_cdb_drive.sv ====
`timescale 1ns/1ps

module fpr_cdb_drive #(
	parameter int TAG_W = 5
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     head_valid,
	input  logic [TAG_W-1:0]         head_tag,
	input  fpr_cdb_pkg::fpr_unit_t   head_unit,
	input  fpr_cdb_pkg::word_t       fdiv_result,
	input  fpr_cdb_pkg::word_t       fsqrt_result,
	input  fpr_cdb_pkg::word_t       fadd_result,
	input  fpr_cdb_pkg::word_t       fmul_result,
	input  fpr_cdb_pkg::word_t       itof_result,
	input  fpr_cdb_pkg::word_t       lw_result,
	input  fpr_cdb_pkg::word_t       fmov_result,
	output logic                     cdb_valid,
	output logic [TAG_W-1:0]         cdb_tag,
	output fpr_cdb_pkg::word_t       cdb_data
);

	fpr_cdb_pkg::word_t sel_data;

	////////////////////////////////////////////////////////////
	// result select for the head slot
	////////////////////////////////////////////////////////////

	always_comb begin
		case (head_unit)
			fpr_cdb_pkg::unit_fdiv:  sel_data = fdiv_result;
			fpr_cdb_pkg::unit_fsqrt: sel_data = fsqrt_result;
			fpr_cdb_pkg::unit_fadd:  sel_data = fadd_result;
			fpr_cdb_pkg::unit_fmul:  sel_data = fmul_result;
			fpr_cdb_pkg::unit_itof:  sel_data = itof_result;
			fpr_cdb_pkg::unit_lw:    sel_data = lw_result;
			default:                 sel_data = fmov_result;
		endcase
	end

	////////////////////////////////////////////////////////////
	// bus register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= head_valid;
		end
	end

	// tag and data keep the last result between slots
	always_ff @(posedge clk) begin
		if (head_valid) begin
			cdb_tag  <= head_tag;
			cdb_data <= sel_data;
		end
	end

endmodule

// ==== src/fpr_result_bus.sv ====
`timescale 1ns/1ps

module fpr_result_bus #(
	parameter int TAG_W     = 5,
	parameter int DIV_SLOT  = 13,
	parameter int ADD_SLOT  = 5,
	parameter int MUL_SLOT  = 3,
	parameter int ITOF_SLOT = 2
) (
	input  logic                  clk,
	input  logic                  rst_n,

	// divide and square root, always accepted
	input  logic                  div_valid,
	input  logic                  div_is_sqrt,
	input  logic [TAG_W-1:0]      div_tag,

	input  logic                  add_valid,
	input  logic [TAG_W-1:0]      add_tag,
	output logic                  add_ready,

	input  logic                  mul_valid,
	input  logic [TAG_W-1:0]      mul_tag,
	output logic                  mul_ready,

	input  logic                  itof_valid,
	input  logic [TAG_W-1:0]      itof_tag,
	output logic                  itof_ready,

	input  logic                  lw_valid,
	input  logic [TAG_W-1:0]      lw_tag,
	output logic                  lw_ready,

	input  logic                  fmov_valid,
	input  logic [TAG_W-1:0]      fmov_tag,
	output logic                  fmov_ready,

	// unit results, sampled the cycle before the bus
	input  fpr_cdb_pkg::word_t    fdiv_result,
	input  fpr_cdb_pkg::word_t    fsqrt_result,
	input  fpr_cdb_pkg::word_t    fadd_result,
	input  fpr_cdb_pkg::word_t    fmul_result,
	input  fpr_cdb_pkg::word_t    itof_result,
	input  fpr_cdb_pkg::word_t    lw_result,
	input  fpr_cdb_pkg::word_t    fmov_result,

	output logic                  cdb_valid,
	output logic [TAG_W-1:0]      cdb_tag,
	output fpr_cdb_pkg::word_t    cdb_data
);

	////////////////////////////////////////////////////////////
	// internal wiring
	////////////////////////////////////////////////////////////

	logic [DIV_SLOT:0]                  occupied;
	logic [fpr_cdb_pkg::n_req-1:0]      accepted;
	logic                               head_valid;
	logic [TAG_W-1:0]                   head_tag;
	fpr_cdb_pkg::fpr_unit_t             head_unit;

	fpr_cdb_grant #(
		.DIV_SLOT(DIV_SLOT),
		.ADD_SLOT(ADD_SLOT),
		.MUL_SLOT(MUL_SLOT),
		.ITOF_SLOT(ITOF_SLOT)
	) u_grant (
		.occupied,
		.div_valid,
		.add_valid,
		.mul_valid,
		.itof_valid,
		.lw_valid,
		.fmov_valid,
		.add_ready,
		.mul_ready,
		.itof_ready,
		.lw_ready,
		.fmov_ready,
		.accepted
	);

	fpr_cdb_slots #(
		.TAG_W(TAG_W),
		.DIV_SLOT(DIV_SLOT),
		.ADD_SLOT(ADD_SLOT),
		.MUL_SLOT(MUL_SLOT),
		.ITOF_SLOT(ITOF_SLOT)
	) u_slots (
		.clk,
		.rst_n,
		.accepted,
		.div_is_sqrt,
		.div_tag,
		.add_tag,
		.mul_tag,
		.itof_tag,
		.lw_tag,
		.fmov_tag,
		.occupied,
		.head_valid,
		.head_tag,
		.head_unit
	);

	fpr_cdb_drive #(
		.TAG_W(TAG_W)
	) u_drive (
		.clk,
		.rst_n,
		.head_valid,
		.head_tag,
		.head_unit,
		.fdiv_result,
		.fsqrt_result,
		.fadd_result,
		.fmul_result,
		.itof_result,
		.lw_result,
		.fmov_result,
		.cdb_valid,
		.cdb_tag,
		.cdb_data
	);

endmodule

// ==== verif/fpr_result_bus_assert.sv ====
`timescale 1ns/1ps

module fpr_result_bus_assert #(
	parameter int TAG_W = 5
) (
	input logic             clk,
	input logic             rst_n,
	input logic             lw_valid,
	input logic             fmov_ready,
	input logic             cdb_valid,
	input logic [TAG_W-1:0] cdb_tag
);

	int n_fail = 0;

	// bus stays quiet through reset
	a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !cdb_valid)
		else begin
			$error("cdb_valid high during reset");
			n_fail++;
		end

	// load owns slot 0 when both ask
	a_lw_first: assert property (@(posedge clk) disable iff (!rst_n) lw_valid |-> !fmov_ready)
		else begin
			$error("fmov_ready high while lw_valid is high");
			n_fail++;
		end

	a_tag_known: assert property (@(posedge clk) disable iff (!rst_n)
		cdb_valid |-> !$isunknown(cdb_tag))
		else begin
			$error("cdb_tag unknown while cdb_valid is high");
			n_fail++;
		end

endmodule

bind fpr_result_bus fpr_result_bus_assert #(.TAG_W(TAG_W)) u_assert (
	.clk,
	.rst_n,
	.lw_valid,
	.fmov_ready,
	.cdb_valid,
	.cdb_tag
);

// ==== verif/fpr_result_bus_stim.svh ====
`ifndef FPR_RESULT_BUS_STIM_SVH
`define FPR_RESULT_BUS_STIM_SVH

// columns: unit, tag, hold, random
// unit 0 fdiv, 1 fsqrt, 2 add, 3 mul, 4 itof, 5 lw, 6 fmov, 7 ends a test (tag = test number)
// hold counts falling edges before the next row, or the number of requests on a random row
localparam int n_rows = 19;

localparam int stim [n_rows][4] = '{
	'{0, 1, 16, 0},
	'{1, 2, 16, 0},
	'{2, 3, 8, 0},
	'{3, 4, 6, 0},
	'{4, 5, 5, 0},
	'{5, 6, 3, 0},
	'{6, 7, 3, 0},
	'{7, 0, 0, 0},
	'{0, 8, 1, 0},
	'{1, 9, 1, 0},
	'{7, 1, 0, 0},
	// divide reaches slot 6 just as the add asks
	'{0, 10, 8, 0},
	'{2, 11, 0, 0},
	'{7, 2, 0, 0},
	'{5, 12, 0, 0},
	'{6, 13, 0, 0},
	'{7, 3, 0, 0},
	'{0, 0, 60, 1},
	'{7, 4, 0, 0}
};

// fixed result word per unit, same order as the unit column
localparam logic [31:0] res_word [7] = '{
	32'h3f80_0d1e, 32'h4000_5a27, 32'h40a0_add0, 32'h4110_3001,
	32'h4f00_1701, 32'hc2c8_0777, 32'h3e4c_f00d
};

`endif

// ==== verif/fpr_result_bus_tb.sv ====
`timescale 1ns/1ps

module fpr_result_bus_tb;

	localparam int TAG_W     = 5;
	localparam int DIV_SLOT  = 13;
	localparam int ADD_SLOT  = 5;
	localparam int MUL_SLOT  = 3;
	localparam int ITOF_SLOT = 2;

	`include "fpr_result_bus_stim.svh"

	logic clk = 1'b1;
	logic rst_n;
	logic div_valid, div_is_sqrt, add_valid, mul_valid, itof_valid, lw_valid, fmov_valid;
	logic [TAG_W-1:0] div_tag, add_tag, mul_tag, itof_tag, lw_tag, fmov_tag;
	logic add_ready, mul_ready, itof_ready, lw_ready, fmov_ready;
	logic cdb_valid;
	logic [TAG_W-1:0] cdb_tag;
	logic [31:0] cdb_data;

	// requests held per port in the order div, add, mul, itof, lw, fmov
	bit pend [6];
	logic [TAG_W-1:0] ptag [6];
	bit psqrt;

	// model of the slot line and the bus register
	bit m_v [DIV_SLOT+1];
	int m_tag [DIV_SLOT+1];
	int m_unit [DIV_SLOT+1];
	bit m_bus_v;
	int m_bus_tag;
	logic [31:0] m_bus_data;

	int errs;
	int checks;
	string test_name [6] = '{"single unit", "div vs sqrt", "slot collision",
		"load over move", "random stream", "reset in flight"};

	fpr_result_bus uut (
		.clk, .rst_n, .div_valid, .div_is_sqrt, .div_tag,
		.add_valid, .add_tag, .add_ready, .mul_valid, .mul_tag, .mul_ready,
		.itof_valid, .itof_tag, .itof_ready, .lw_valid, .lw_tag, .lw_ready,
		.fmov_valid, .fmov_tag, .fmov_ready,
		.fdiv_result(res_word[0]), .fsqrt_result(res_word[1]), .fadd_result(res_word[2]),
		.fmul_result(res_word[3]), .itof_result(res_word[4]), .lw_result(res_word[5]),
		.fmov_result(res_word[6]), .cdb_valid, .cdb_tag, .cdb_data
	);

	always #10 clk = ~clk;

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errs++;
			$display("MISMATCH %s got=%h exp=%h", name, got, exp);
		end
	endtask

	function automatic int port_of(input int u);
		return (u <= 1) ? 0 : u - 1;
	endfunction

	function automatic bit busy();
		bit b;
		b = m_bus_v;
		for (int i = 0; i <= DIV_SLOT; i++)
			b |= m_v[i];
		for (int p = 0; p < 6; p++)
			b |= pend[p];
		return b;
	endfunction

	task automatic apply_inputs();
		div_valid   = pend[0];
		div_tag     = ptag[0];
		div_is_sqrt = psqrt;
		add_valid   = pend[1];
		add_tag     = ptag[1];
		mul_valid   = pend[2];
		mul_tag     = ptag[2];
		itof_valid  = pend[3];
		itof_tag    = ptag[3];
		lw_valid    = pend[4];
		lw_tag      = ptag[4];
		fmov_valid  = pend[5];
		fmov_tag    = ptag[5];
	endtask

	task automatic step();
		@(negedge clk);
		apply_inputs();
	endtask

	task automatic launch(input int u, input int t);
		int p;
		int n;
		p = port_of(u);
		n = 0;
		while (pend[p] && n < 50) begin
			step();
			n++;
		end
		if (pend[p]) begin
			errs++;
			$display("timeout: request on unit %0d was never accepted", u);
		end
		pend[p] = 1'b1;
		ptag[p] = t;
		if (p == 0)
			psqrt = (u == 1);
		apply_inputs();
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (busy() && n < 200) begin
			step();
			n++;
		end
		if (busy()) begin
			errs++;
			$display("timeout: results still in flight after 200 cycles");
		end
	endtask

	////////////////////////////////////////////////////////////
	// reference model sampled on the rising edge
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		bit r_add, r_mul, r_itof, r_lw, r_fmov;
		bit acc [6];
		if (!rst_n) begin
			check("cdb_valid", cdb_valid, 0);
			m_bus_v = 1'b0;
			for (int i = 0; i <= DIV_SLOT; i++)
				m_v[i] = 1'b0;
		end else begin
			r_add  = !m_v[ADD_SLOT+1];
			r_mul  = !m_v[MUL_SLOT+1];
			r_itof = !m_v[ITOF_SLOT+1];
			r_lw   = !m_v[1];
			r_fmov = !m_v[1] && !lw_valid;
			check("add_ready", add_ready, r_add);
			check("mul_ready", mul_ready, r_mul);
			check("itof_ready", itof_ready, r_itof);
			check("lw_ready", lw_ready, r_lw);
			check("fmov_ready", fmov_ready, r_fmov);
			check("cdb_valid", cdb_valid, m_bus_v);
			if (m_bus_v) begin
				check("cdb_tag", cdb_tag, m_bus_tag);
				check("cdb_data", cdb_data, m_bus_data);
			end
			acc[0] = div_valid;
			acc[1] = add_valid && r_add;
			acc[2] = mul_valid && r_mul;
			acc[3] = itof_valid && r_itof;
			acc[4] = lw_valid && r_lw;
			acc[5] = fmov_valid && r_fmov;
			// slot 0 leaves for the bus register
			m_bus_v = m_v[0];
			if (m_v[0]) begin
				m_bus_tag  = m_tag[0];
				m_bus_data = res_word[m_unit[0]];
			end
			for (int i = 0; i < DIV_SLOT; i++) begin
				m_v[i]    = m_v[i+1];
				m_tag[i]  = m_tag[i+1];
				m_unit[i] = m_unit[i+1];
			end
			m_v[DIV_SLOT]    = acc[0];
			m_tag[DIV_SLOT]  = div_tag;
			m_unit[DIV_SLOT] = div_is_sqrt ? 1 : 0;
			if (acc[1]) begin
				m_v[ADD_SLOT]    = 1'b1;
				m_tag[ADD_SLOT]  = add_tag;
				m_unit[ADD_SLOT] = 2;
			end
			if (acc[2]) begin
				m_v[MUL_SLOT]    = 1'b1;
				m_tag[MUL_SLOT]  = mul_tag;
				m_unit[MUL_SLOT] = 3;
			end
			if (acc[3]) begin
				m_v[ITOF_SLOT]    = 1'b1;
				m_tag[ITOF_SLOT]  = itof_tag;
				m_unit[ITOF_SLOT] = 4;
			end
			if (acc[4] || acc[5]) begin
				m_v[0]    = 1'b1;
				m_tag[0]  = acc[4] ? lw_tag : fmov_tag;
				m_unit[0] = acc[4] ? 5 : 6;
			end
			for (int p = 0; p < 6; p++)
				if (acc[p])
					pend[p] = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// table loop
	////////////////////////////////////////////////////////////

	initial begin
		int e0;
		int w;
		void'($urandom(32'hb5ea));
		errs   = 0;
		checks = 0;
		rst_n  = 1'b1;
		psqrt  = 1'b0;
		for (int p = 0; p < 6; p++) begin
			pend[p] = 1'b0;
			ptag[p] = '0;
		end
		apply_inputs();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		e0 = 0;

		for (int r = 0; r < n_rows; r++) begin
			if (stim[r][0] == 7) begin
				drain();
				$display("test %0d %s: %s", stim[r][1], test_name[stim[r][1]],
					(errs == e0) ? "ok" : "errors");
				e0 = errs;
			end else if (stim[r][3] != 0) begin
				for (int k = 0; k < stim[r][2]; k++) begin
					launch($urandom_range(0, 6), $urandom_range(0, 31));
					w = $urandom_range(0, 1);
					repeat (w) step();
				end
			end else begin
				launch(stim[r][0], stim[r][1]);
				repeat (stim[r][2]) step();
			end
		end

		// divides cleared by reset must never reach the bus
		for (int k = 0; k < 3; k++) begin
			launch((k == 1) ? 1 : 0, 20 + k);
			step();
		end
		repeat (4) step();
		rst_n = 1'b0;
		for (int p = 0; p < 6; p++)
			pend[p] = 1'b0;
		apply_inputs();
		repeat (5) step();
		rst_n = 1'b1;
		repeat (DIV_SLOT + 6) step();
		$display("test 5 %s: %s", test_name[5], (errs == e0) ? "ok" : "errors");

		// bound assertion failures
		errs += uut.u_assert.n_fail;
		$display("tests 6, checks %0d, errors %0d", checks, errs);
		if (errs == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== fpr_result_bus.f ====
+incdir+verif
src/fpr_cdb_pkg.sv
src/fpr_cdb_grant.sv
src/fpr_cdb_slots.sv
src/fpr_cdb_drive.sv
src/fpr_result_bus.sv
verif/fpr_result_bus_assert.sv
verif/fpr_result_bus_tb.sv

// ==== Bender.yml ====
package:
  name: fpr_result_bus

sources:
  - files:
      - src/fpr_cdb_pkg.sv
      - src/fpr_cdb_grant.sv
      - src/fpr_cdb_slots.sv
      - src/fpr_cdb_drive.sv
      - src/fpr_result_bus.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/fpr_result_bus_assert.sv
      - verif/fpr_result_bus_tb.sv
